// File: Bender.yml
package:
  name: openmips

sources:
  - src/mips_isa_pkg.sv
  - src/mips_core_pkg.sv
  - src/pc_reg.sv
  - src/regfile.sv
  - src/id_stage.sv
  - src/ex_stage.sv
  - src/ctrl_regs.sv
  - src/openmips_core.sv
  - src/openmips.sv
  - target: simulation
    files:
      - sim/clk_gen.sv
      - sim/tb_openmips.sv

// File: build.f
src/mips_isa_pkg.sv
src/mips_core_pkg.sv
src/pc_reg.sv
src/regfile.sv
src/id_stage.sv
src/ex_stage.sv
src/ctrl_regs.sv
src/openmips_core.sv
src/openmips.sv
sim/clk_gen.sv
sim/tb_openmips.sv

// File: sim/clk_gen.sv
// clk_gen: free-running testbench clock
`timescale 1ns/1ps

module clk_gen (
    output logic clk_o
);

    localparam int PERIOD = 20;  // ns

    initial begin
        clk_o = 1'b0;
    end

    always #(PERIOD / 2) clk_o = ~clk_o;

endmodule

// File: sim/tb_openmips.sv
// ROM model, APB tasks, reference model, directed tests and watchdog
`timescale 1ns/1ps

module tb_openmips;

    localparam int CLK_PERIOD      = 20;
    localparam int NUM_TESTS       = 5;
    localparam int CYCLES_PER_TEST = 200;

    logic                    clk;
    logic                    rst_n;
    logic                    rom_ce;
    mips_isa_pkg::word_t     rom_addr;
    mips_isa_pkg::inst_t     rom_data;
    mips_core_pkg::apb_req_t apb_req;
    mips_core_pkg::apb_rsp_t apb_rsp;

    mips_isa_pkg::inst_t rom [64];
    int                  prog_len;
    mips_isa_pkg::word_t model [32];  // expected register file
    int                  errors;
    int                  failed_tests;
    integer              seed;

    clk_gen clk_gen_0 (.clk_o(clk));

    openmips dut (
        .clk_i      (clk),
        .rst_n_i    (rst_n),
        .rom_data_i (rom_data),
        .rom_ce_o   (rom_ce),
        .rom_addr_o (rom_addr),
        .apb_i      (apb_req),
        .apb_o      (apb_rsp)
    );

    // combinational ROM returning nops past the loaded program
    assign rom_data = (rom_addr[31:2] < prog_len) ? rom[rom_addr[7:2]] : mips_isa_pkg::NOP_INST;

    task automatic check_value(input string name, input mips_isa_pkg::word_t got,
                               input mips_isa_pkg::word_t exp);
        if (got !== exp) begin
            $display("ERROR t=%0t %s: expected %h, got %h", $time, name, exp, got);
            errors++;
        end
    endtask

    // one APB transfer, setup then access, sampled mid access cycle
    task automatic apb_access(input logic write, input mips_core_pkg::apb_addr_t addr,
                              input mips_isa_pkg::word_t wdata, input logic exp_err,
                              output mips_isa_pkg::word_t rdata);
        @(negedge clk);
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = write;
        apb_req.paddr   = addr;
        apb_req.pwdata  = wdata;
        @(negedge clk);
        apb_req.penable = 1'b1;
        #(CLK_PERIOD / 4);
        rdata = apb_rsp.prdata;
        if (apb_rsp.pready !== 1'b1) begin
            $display("ERROR t=%0t pready at %h: expected 1, got %b",
                     $time, addr, apb_rsp.pready);
            errors++;
        end
        if (apb_rsp.pslverr !== exp_err) begin
            $display("ERROR t=%0t pslverr at %h: expected %b, got %b",
                     $time, addr, exp_err, apb_rsp.pslverr);
            errors++;
        end
        @(negedge clk);  // transfer done at the posedge before this
        apb_req.psel    = 1'b0;
        apb_req.penable = 1'b0;
    endtask

    task automatic apb_write(input mips_core_pkg::apb_addr_t addr,
                             input mips_isa_pkg::word_t data, input logic exp_err);
        mips_isa_pkg::word_t unused;
        apb_access(1'b1, addr, data, exp_err, unused);
    endtask

    task automatic apb_read(input mips_core_pkg::apb_addr_t addr,
                            output mips_isa_pkg::word_t data, input logic exp_err);
        apb_access(1'b0, addr, '0, exp_err, data);
    endtask

    task automatic reset_dut();
        @(negedge clk);
        rst_n    = 1'b0;
        apb_req  = '0;
        prog_len = 0;
        for (int i = 0; i < 32; i++) model[i] = '0;
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
    endtask

    function automatic mips_isa_pkg::inst_t r_type(input mips_isa_pkg::funct_t fn,
            input mips_isa_pkg::reg_idx_t rd, input mips_isa_pkg::reg_idx_t rs,
            input mips_isa_pkg::reg_idx_t rt);
        return {mips_isa_pkg::OP_SPECIAL, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic mips_isa_pkg::inst_t i_type(input mips_isa_pkg::opcode_t op,
            input mips_isa_pkg::reg_idx_t rt, input mips_isa_pkg::reg_idx_t rs,
            input mips_isa_pkg::imm_t imm);
        return {op, rs, rt, imm};
    endfunction

    // reference model of the instruction set where dest 0 means no write
    task automatic apply_model(input mips_isa_pkg::inst_t inst);
        mips_isa_pkg::word_t    a;
        mips_isa_pkg::word_t    b;
        mips_isa_pkg::word_t    imm;
        mips_isa_pkg::word_t    res;
        mips_isa_pkg::reg_idx_t dest;
        a    = model[inst[25:21]];
        b    = model[inst[20:16]];
        imm  = {16'h0000, inst[15:0]};
        dest = inst[20:16];
        res  = '0;
        case (inst[31:26])
            mips_isa_pkg::OP_SPECIAL: begin
                dest = inst[15:11];
                case (inst[5:0])
                    mips_isa_pkg::FN_ADDU: res = a + b;
                    mips_isa_pkg::FN_SUBU: res = a - b;
                    mips_isa_pkg::FN_AND:  res = a & b;
                    mips_isa_pkg::FN_OR:   res = a | b;
                    mips_isa_pkg::FN_XOR:  res = a ^ b;
                    default:               dest = '0;
                endcase
            end
            mips_isa_pkg::OP_ORI:  res = a | imm;
            mips_isa_pkg::OP_ANDI: res = a & imm;
            mips_isa_pkg::OP_XORI: res = a ^ imm;
            mips_isa_pkg::OP_LUI:  res = {inst[15:0], 16'h0000};
            default:               dest = '0;
        endcase
        if (dest != '0) model[dest] = res;  // r0 stays zero
    endtask

    task automatic load_inst(input mips_isa_pkg::inst_t inst);
        rom[prog_len] = inst;
        prog_len++;
        apply_model(inst);
    endtask

    task automatic wait_retired(input int target);
        mips_isa_pkg::word_t count;
        int                  reads;
        count = '0;
        reads = 0;
        while (count < target && reads < 64) begin
            apb_read(mips_core_pkg::REG_RETIRED, count, 1'b0);
            reads++;
        end
        if (count < target) begin
            $display("retired count stuck at %0d, wanted %0d within 64 reads", count, target);
            errors++;
        end
    endtask

    // every loaded instruction writes a register, so each one retires
    task automatic run_program();
        mips_isa_pkg::word_t count;
        apb_write(mips_core_pkg::REG_CTRL, 32'd1, 1'b0);
        wait_retired(prog_len);
        apb_write(mips_core_pkg::REG_CTRL, 32'd0, 1'b0);
        apb_read(mips_core_pkg::REG_RETIRED, count, 1'b0);
        check_value("RETIRED", count, prog_len);
    endtask

    task automatic check_regs(input int first, input int last);
        mips_isa_pkg::word_t got;
        for (int i = first; i <= last; i++) begin
            apb_write(mips_core_pkg::REG_SEL, i, 1'b0);
            apb_read(mips_core_pkg::REG_DATA, got, 1'b0);
            check_value($sformatf("DATA r%0d", i), got, model[i]);
        end
    endtask

    task automatic end_test(input string name, input int err_at_start);
        if (errors == err_at_start) begin
            $display("test %s: passed", name);
        end else begin
            failed_tests++;
            $display("test %s: failed with %0d errors", name, errors - err_at_start);
        end
    endtask

    task automatic test_reset();
        int                  err0;
        mips_isa_pkg::word_t got;
        err0 = errors;
        reset_dut();
        check_value("rom_ce_o", {31'd0, rom_ce}, '0);
        check_value("rom_addr_o", rom_addr, '0);
        apb_read(mips_core_pkg::REG_CTRL, got, 1'b0);
        check_value("CTRL", got, '0);
        apb_read(mips_core_pkg::REG_PC, got, 1'b0);
        check_value("PC", got, '0);
        apb_read(mips_core_pkg::REG_RETIRED, got, 1'b0);
        check_value("RETIRED", got, '0);
        apb_read(mips_core_pkg::REG_SEL, got, 1'b0);
        check_value("SEL", got, '0);
        check_regs(5, 5);
        apb_read(8'h14, got, 1'b1);  // hole in the map
        apb_write(mips_core_pkg::REG_PC, 32'h0000_0100, 1'b1);
        apb_read(mips_core_pkg::REG_PC, got, 1'b0);
        check_value("PC after write", got, '0);
        end_test("reset state", err0);
    endtask

    task automatic test_immediate();
        int err0;
        err0 = errors;
        reset_dut();
        load_inst(i_type(mips_isa_pkg::OP_LUI, 5'd1, 5'd0, 16'hdead));
        load_inst(i_type(mips_isa_pkg::OP_ORI, 5'd2, 5'd0, 16'hbeef));
        load_inst(i_type(mips_isa_pkg::OP_ORI, 5'd3, 5'd0, 16'h0ff0));
        load_inst(i_type(mips_isa_pkg::OP_ANDI, 5'd4, 5'd2, 16'h00ff));
        load_inst(i_type(mips_isa_pkg::OP_XORI, 5'd5, 5'd2, 16'hffff));
        load_inst(i_type(mips_isa_pkg::OP_XORI, 5'd6, 5'd1, 16'h1234));
        run_program();
        check_regs(1, 6);
        end_test("immediate", err0);
    endtask

    task automatic test_forwarding();
        int err0;
        err0 = errors;
        reset_dut();
        load_inst(i_type(mips_isa_pkg::OP_ORI, 5'd1, 5'd0, 16'h1234));
        load_inst(r_type(mips_isa_pkg::FN_ADDU, 5'd2, 5'd1, 5'd1));  // EX
        load_inst(r_type(mips_isa_pkg::FN_XOR, 5'd3, 5'd2, 5'd1));   // EX and MEM
        load_inst(r_type(mips_isa_pkg::FN_SUBU, 5'd4, 5'd3, 5'd2));
        load_inst(i_type(mips_isa_pkg::OP_LUI, 5'd5, 5'd0, 16'h8001));
        load_inst(r_type(mips_isa_pkg::FN_OR, 5'd6, 5'd4, 5'd5));
        load_inst(i_type(mips_isa_pkg::OP_ANDI, 5'd7, 5'd6, 16'hf0f0));
        load_inst(r_type(mips_isa_pkg::FN_AND, 5'd8, 5'd7, 5'd6));
        load_inst(r_type(mips_isa_pkg::FN_ADDU, 5'd9, 5'd8, 5'd6));  // r6 via regfile
        run_program();
        check_regs(1, 9);
        end_test("forwarding", err0);
    endtask

    task automatic test_rtype();
        int                  err0;
        mips_isa_pkg::word_t x;
        mips_isa_pkg::word_t y;
        err0 = errors;
        reset_dut();
        x = $random(seed);
        y = $random(seed);
        load_inst(i_type(mips_isa_pkg::OP_LUI, 5'd10, 5'd0, x[31:16]));
        load_inst(i_type(mips_isa_pkg::OP_ORI, 5'd10, 5'd10, x[15:0]));
        load_inst(i_type(mips_isa_pkg::OP_LUI, 5'd11, 5'd0, y[31:16]));
        load_inst(i_type(mips_isa_pkg::OP_ORI, 5'd11, 5'd11, y[15:0]));
        load_inst(r_type(mips_isa_pkg::FN_ADDU, 5'd12, 5'd10, 5'd11));
        load_inst(r_type(mips_isa_pkg::FN_SUBU, 5'd13, 5'd10, 5'd11));
        load_inst(r_type(mips_isa_pkg::FN_AND, 5'd14, 5'd10, 5'd11));
        load_inst(r_type(mips_isa_pkg::FN_OR, 5'd15, 5'd10, 5'd11));
        load_inst(r_type(mips_isa_pkg::FN_XOR, 5'd16, 5'd10, 5'd11));
        load_inst(r_type(mips_isa_pkg::FN_ADDU, 5'd0, 5'd10, 5'd11));  // dropped by r0
        run_program();
        check_regs(10, 16);
        check_regs(0, 0);
        end_test("r-type", err0);
    endtask

    task automatic test_halt();
        int                  err0;
        mips_isa_pkg::word_t pc1;
        mips_isa_pkg::word_t pc2;
        mips_isa_pkg::word_t got;
        err0 = errors;
        reset_dut();
        for (int i = 1; i <= 10; i++) begin
            load_inst(i_type((i % 2) ? mips_isa_pkg::OP_ORI : mips_isa_pkg::OP_XORI,
                             5'(i), 5'(i - 1), 16'(i * 16'h0123)));
        end
        apb_write(mips_core_pkg::REG_CTRL, 32'd1, 1'b0);
        apb_write(mips_core_pkg::REG_CTRL, 32'd0, 1'b0);  // only a few fetches get in
        apb_read(mips_core_pkg::REG_PC, pc1, 1'b0);
        repeat (5) @(negedge clk);
        apb_read(mips_core_pkg::REG_PC, pc2, 1'b0);
        check_value("PC while halted", pc2, pc1);
        check_value("rom_ce_o", {31'd0, rom_ce}, '0);
        apb_read(mips_core_pkg::REG_RETIRED, got, 1'b0);
        if (got >= prog_len) begin
            $display("halt came too late, %0d of %0d instructions retired", got, prog_len);
            errors++;
        end
        run_program();
        check_regs(1, 10);
        apb_write(mips_core_pkg::REG_RETIRED, 32'h0000_00ff, 1'b0);
        apb_read(mips_core_pkg::REG_RETIRED, got, 1'b0);
        check_value("RETIRED after clear", got, '0);
        end_test("halt and resume", err0);
    endtask

    initial begin
        seed         = 98;
        errors       = 0;
        failed_tests = 0;
        prog_len     = 0;
        rst_n        = 1'b0;
        apb_req      = '0;
        test_reset();
        test_immediate();
        test_forwarding();
        test_rtype();
        test_halt();
        $display("tests run %0d, passed %0d, failed %0d, errors %0d",
                 NUM_TESTS, NUM_TESTS - failed_tests, failed_tests, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    // watchdog sized from the test count
    initial begin
        #(NUM_TESTS * CYCLES_PER_TEST * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, a test hung", NUM_TESTS * CYCLES_PER_TEST);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

// File: src/ctrl_regs.sv
// ctrl_regs: APB slave with run control, PC view, retired counter, debug window
`timescale 1ns/1ps

module ctrl_regs (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  mips_core_pkg::apb_req_t apb_i,
    output mips_core_pkg::apb_rsp_t apb_o,
    input  mips_isa_pkg::word_t     pc_i,
    input  logic                    retire_i,
    input  mips_isa_pkg::word_t     dbg_data_i,
    output mips_core_pkg::dbg_t     dbg_o
);

    logic                   run_q;
    mips_isa_pkg::reg_idx_t sel_q;
    mips_isa_pkg::word_t    retired_q;
    logic                   access;
    logic                   wr;
    logic                   addr_ok;
    logic                   addr_ro;

    assign access = apb_i.psel && apb_i.penable;  // no wait states
    assign wr     = access && apb_i.pwrite;

    always_comb begin
        addr_ok      = 1'b1;
        addr_ro      = 1'b0;
        apb_o.prdata = '0;
        case (apb_i.paddr)
            mips_core_pkg::REG_CTRL:    apb_o.prdata = {31'd0, run_q};
            mips_core_pkg::REG_PC:      begin apb_o.prdata = pc_i; addr_ro = 1'b1; end
            mips_core_pkg::REG_RETIRED: apb_o.prdata = retired_q;
            mips_core_pkg::REG_SEL:     apb_o.prdata = {27'd0, sel_q};
            mips_core_pkg::REG_DATA:    begin apb_o.prdata = dbg_data_i; addr_ro = 1'b1; end
            default:                    addr_ok = 1'b0;
        endcase
    end

    assign apb_o.pready  = 1'b1;
    assign apb_o.pslverr = access && (!addr_ok || (apb_i.pwrite && addr_ro));

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            run_q     <= 1'b0;
            sel_q     <= '0;
            retired_q <= '0;
        end else begin
            if (wr && apb_i.paddr == mips_core_pkg::REG_CTRL) run_q <= apb_i.pwdata[0];
            if (wr && apb_i.paddr == mips_core_pkg::REG_SEL)  sel_q <= apb_i.pwdata[4:0];
            // any write clears, clear beats a retire in the same cycle
            if (wr && apb_i.paddr == mips_core_pkg::REG_RETIRED) begin
                retired_q <= '0;
            end else if (retire_i) begin
                retired_q <= retired_q + 32'd1;
            end
        end
    end

    assign dbg_o.run = run_q;
    assign dbg_o.sel = sel_q;

endmodule

// File: src/ex_stage.sv
// ex_stage: ALU for addu, subu, and, or, xor and lui
`timescale 1ns/1ps

module ex_stage (
    input  mips_core_pkg::id_ex_t id_ex_i,
    output mips_core_pkg::wb_t    ex_o
);

    mips_isa_pkg::word_t result;

    always_comb begin
        case (id_ex_i.op)
            mips_isa_pkg::addu:   result = id_ex_i.a + id_ex_i.b;
            mips_isa_pkg::subu:   result = id_ex_i.a - id_ex_i.b;
            mips_isa_pkg::and_op: result = id_ex_i.a & id_ex_i.b;
            mips_isa_pkg::or_op:  result = id_ex_i.a | id_ex_i.b;
            mips_isa_pkg::xor_op: result = id_ex_i.a ^ id_ex_i.b;
            mips_isa_pkg::lui:    result = {id_ex_i.b[15:0], 16'h0000};  // imm to upper half
            default:              result = '0;
        endcase
    end

    assign ex_o.rd   = id_ex_i.rd;
    assign ex_o.we   = id_ex_i.we;
    assign ex_o.data = result;

endmodule

// File: src/id_stage.sv
// id_stage: instruction decode, operand select and EX/MEM forwarding
`timescale 1ns/1ps

module id_stage (
    input  mips_isa_pkg::word_t    pc_i,
    input  mips_isa_pkg::inst_t    inst_i,
    input  mips_isa_pkg::word_t    rdata1_i,
    input  mips_isa_pkg::word_t    rdata2_i,
    input  mips_core_pkg::wb_t     ex_fwd_i,
    input  mips_core_pkg::wb_t     mem_fwd_i,
    output mips_isa_pkg::reg_idx_t raddr1_o,
    output mips_isa_pkg::reg_idx_t raddr2_o,
    output mips_core_pkg::id_ex_t  id_ex_o
);

    mips_isa_pkg::opcode_t  opcode;
    mips_isa_pkg::funct_t   funct;
    mips_isa_pkg::reg_idx_t rs;
    mips_isa_pkg::reg_idx_t rt;
    mips_isa_pkg::reg_idx_t rd;
    mips_isa_pkg::imm_t     imm;
    mips_isa_pkg::alu_op_e  alu_op;
    logic                   use_imm;
    logic                   wr_en;

    assign opcode = inst_i[31:26];
    assign rs     = inst_i[25:21];
    assign rt     = inst_i[20:16];
    assign rd     = inst_i[15:11];
    assign funct  = inst_i[5:0];
    assign imm    = inst_i[15:0];

    assign raddr1_o = rs;
    assign raddr2_o = rt;

    // youngest producer first, then regfile (which already covers WB)
    function automatic mips_isa_pkg::word_t fwd(
        input mips_isa_pkg::reg_idx_t idx,
        input mips_isa_pkg::word_t    rf_data,
        input mips_core_pkg::wb_t     ex_w,
        input mips_core_pkg::wb_t     mem_w
    );
        if (idx == '0) return '0;
        if (ex_w.we && ex_w.rd == idx) return ex_w.data;
        if (mem_w.we && mem_w.rd == idx) return mem_w.data;
        return rf_data;
    endfunction

    always_comb begin
        alu_op  = mips_isa_pkg::nop;
        use_imm = 1'b1;
        wr_en   = 1'b0;
        case (opcode)
            mips_isa_pkg::OP_SPECIAL: begin
                use_imm = 1'b0;
                wr_en   = 1'b1;
                case (funct)
                    mips_isa_pkg::FN_ADDU: alu_op = mips_isa_pkg::addu;
                    mips_isa_pkg::FN_SUBU: alu_op = mips_isa_pkg::subu;
                    mips_isa_pkg::FN_AND:  alu_op = mips_isa_pkg::and_op;
                    mips_isa_pkg::FN_OR:   alu_op = mips_isa_pkg::or_op;
                    mips_isa_pkg::FN_XOR:  alu_op = mips_isa_pkg::xor_op;
                    default:               wr_en  = 1'b0;  // incl. all-zero nop
                endcase
            end
            mips_isa_pkg::OP_ORI:  begin alu_op = mips_isa_pkg::or_op;  wr_en = 1'b1; end
            mips_isa_pkg::OP_ANDI: begin alu_op = mips_isa_pkg::and_op; wr_en = 1'b1; end
            mips_isa_pkg::OP_XORI: begin alu_op = mips_isa_pkg::xor_op; wr_en = 1'b1; end
            mips_isa_pkg::OP_LUI:  begin alu_op = mips_isa_pkg::lui;    wr_en = 1'b1; end
            default: ;
        endcase
    end

    always_comb begin
        id_ex_o.op = wr_en ? alu_op : mips_isa_pkg::nop;
        id_ex_o.we = wr_en;
        id_ex_o.rd = use_imm ? rt : rd;
        // bubbles carry their fetch address in operand a, handy in waves
        id_ex_o.a  = wr_en ? fwd(rs, rdata1_i, ex_fwd_i, mem_fwd_i) : pc_i;
        id_ex_o.b  = use_imm ? {16'h0000, imm} : fwd(rt, rdata2_i, ex_fwd_i, mem_fwd_i);
    end

endmodule

// File: src/mips_core_pkg.sv
// core package: pipeline stage structs, APB types, control register map
package mips_core_pkg;

    typedef logic [7:0] apb_addr_t;

    // decode to execute
    typedef struct packed {
        mips_isa_pkg::alu_op_e  op;
        mips_isa_pkg::word_t    a;
        mips_isa_pkg::word_t    b;
        mips_isa_pkg::reg_idx_t rd;
        logic                   we;
    } id_ex_t;

    // result on its way to the register file, also the forwarding bus
    typedef struct packed {
        mips_isa_pkg::reg_idx_t rd;
        logic                   we;
        mips_isa_pkg::word_t    data;
    } wb_t;

    typedef struct packed {
        logic                psel;
        logic                penable;
        logic                pwrite;
        apb_addr_t           paddr;
        mips_isa_pkg::word_t pwdata;
    } apb_req_t;

    typedef struct packed {
        mips_isa_pkg::word_t prdata;
        logic                pready;
        logic                pslverr;
    } apb_rsp_t;

    // control block to core
    typedef struct packed {
        logic                   run;
        mips_isa_pkg::reg_idx_t sel;
    } dbg_t;

    // register map
    localparam apb_addr_t REG_CTRL    = 8'h00;
    localparam apb_addr_t REG_PC      = 8'h04;
    localparam apb_addr_t REG_RETIRED = 8'h08;
    localparam apb_addr_t REG_SEL     = 8'h0C;
    localparam apb_addr_t REG_DATA    = 8'h10;

    localparam mips_isa_pkg::word_t PC_STEP = 32'd4;

    // bubbles
    localparam id_ex_t ID_EX_NOP = '{op: mips_isa_pkg::nop, a: '0, b: '0, rd: '0, we: 1'b0};
    localparam wb_t    WB_NOP    = '{rd: '0, we: 1'b0, data: '0};

endpackage

// File: src/mips_isa_pkg.sv
// MIPS ISA package: word and index types, opcode/funct encodings, ALU op enum
package mips_isa_pkg;

    typedef logic [31:0] word_t;     // data and address word
    typedef logic [31:0] inst_t;     // raw instruction word
    typedef logic [4:0]  reg_idx_t;  // gpr index
    typedef logic [5:0]  opcode_t;   // inst[31:26]
    typedef logic [5:0]  funct_t;    // inst[5:0] of SPECIAL
    typedef logic [15:0] imm_t;      // inst[15:0]

    typedef enum logic [2:0] {
        nop,
        addu,
        subu,
        and_op,
        or_op,
        xor_op,
        lui
    } alu_op_e;

    // major opcodes
    localparam opcode_t OP_SPECIAL = 6'b000000;
    localparam opcode_t OP_ANDI    = 6'b001100;
    localparam opcode_t OP_ORI     = 6'b001101;
    localparam opcode_t OP_XORI    = 6'b001110;
    localparam opcode_t OP_LUI     = 6'b001111;

    // SPECIAL funct field
    localparam funct_t FN_ADDU = 6'b100001;
    localparam funct_t FN_SUBU = 6'b100011;
    localparam funct_t FN_AND  = 6'b100100;
    localparam funct_t FN_OR   = 6'b100101;
    localparam funct_t FN_XOR  = 6'b100110;

    localparam inst_t NOP_INST = 32'h0000_0000;  // sll r0,r0,0

endpackage

// File: src/openmips.sv
// openmips: top level with pipeline core and APB control block
`timescale 1ns/1ps

module openmips (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  mips_isa_pkg::inst_t     rom_data_i,
    output logic                    rom_ce_o,
    output mips_isa_pkg::word_t     rom_addr_o,
    input  mips_core_pkg::apb_req_t apb_i,
    output mips_core_pkg::apb_rsp_t apb_o
);

    mips_core_pkg::dbg_t dbg;
    mips_isa_pkg::word_t pc;
    mips_isa_pkg::word_t dbg_data;
    logic                retire;

    openmips_core openmips_core_0 (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .rom_data_i (rom_data_i),
        .rom_ce_o   (rom_ce_o),
        .rom_addr_o (rom_addr_o),
        .dbg_i      (dbg),
        .pc_o       (pc),
        .retire_o   (retire),
        .dbg_data_o (dbg_data)
    );

    ctrl_regs ctrl_regs_0 (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .apb_i      (apb_i),
        .apb_o      (apb_o),
        .pc_i       (pc),
        .retire_i   (retire),
        .dbg_data_i (dbg_data),
        .dbg_o      (dbg)
    );

endmodule

// File: src/openmips_core.sv
// openmips_core: five-stage pipeline, stage registers and stage instances
`timescale 1ns/1ps

module openmips_core (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  mips_isa_pkg::inst_t rom_data_i,
    output logic                rom_ce_o,
    output mips_isa_pkg::word_t rom_addr_o,
    input  mips_core_pkg::dbg_t dbg_i,
    output mips_isa_pkg::word_t pc_o,
    output logic                retire_o,
    output mips_isa_pkg::word_t dbg_data_o
);

    typedef struct packed {
        mips_isa_pkg::word_t pc;
        mips_isa_pkg::inst_t inst;
    } if_id_t;

    mips_isa_pkg::word_t    if_pc;
    if_id_t                 if_id_q;
    mips_core_pkg::id_ex_t  id_ex_d;
    mips_core_pkg::id_ex_t  id_ex_q;
    mips_core_pkg::wb_t     ex_d;
    mips_core_pkg::wb_t     ex_mem_q;
    mips_core_pkg::wb_t     mem_wb_q;
    mips_isa_pkg::reg_idx_t rf_raddr1;
    mips_isa_pkg::reg_idx_t rf_raddr2;
    mips_isa_pkg::word_t    rf_rdata1;
    mips_isa_pkg::word_t    rf_rdata2;

    // IF
    pc_reg pc_reg_0 (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .run_i   (dbg_i.run),
        .pc_o    (if_pc),
        .ce_o    (rom_ce_o)
    );

    assign rom_addr_o = if_pc;
    assign pc_o       = if_pc;

    // ID
    id_stage id_stage_0 (
        .pc_i      (if_id_q.pc),
        .inst_i    (if_id_q.inst),
        .rdata1_i  (rf_rdata1),
        .rdata2_i  (rf_rdata2),
        .ex_fwd_i  (ex_d),      // distance 1
        .mem_fwd_i (ex_mem_q),  // distance 2
        .raddr1_o  (rf_raddr1),
        .raddr2_o  (rf_raddr2),
        .id_ex_o   (id_ex_d)
    );

    regfile regfile_0 (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .raddr1_i   (rf_raddr1),
        .raddr2_i   (rf_raddr2),
        .dbg_addr_i (dbg_i.sel),
        .wb_i       (mem_wb_q),
        .rdata1_o   (rf_rdata1),
        .rdata2_o   (rf_rdata2),
        .dbg_data_o (dbg_data_o)
    );

    // EX
    ex_stage ex_stage_0 (
        .id_ex_i (id_ex_q),
        .ex_o    (ex_d)
    );

    // stage registers, no stalls so everything moves each clock
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            if_id_q  <= '{pc: '0, inst: mips_isa_pkg::NOP_INST};
            id_ex_q  <= mips_core_pkg::ID_EX_NOP;
            ex_mem_q <= mips_core_pkg::WB_NOP;
            mem_wb_q <= mips_core_pkg::WB_NOP;
        end else begin
            if_id_q.pc   <= if_pc;
            if_id_q.inst <= rom_ce_o ? rom_data_i : mips_isa_pkg::NOP_INST;  // bubble when halted
            id_ex_q      <= id_ex_d;
            ex_mem_q     <= ex_d;
            mem_wb_q     <= ex_mem_q;  // MEM has no memory, result passes on
        end
    end

    assign retire_o = mem_wb_q.we;

endmodule

// File: src/pc_reg.sv
// pc_reg: fetch address register and ROM enable
`timescale 1ns/1ps

module pc_reg (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic                run_i,
    output mips_isa_pkg::word_t pc_o,
    output logic                ce_o
);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            pc_o <= '0;
            ce_o <= 1'b0;
        end else begin
            ce_o <= run_i;  // enable lags run by one clock
            // step only once the current address has been fetched
            if (ce_o) begin
                pc_o <= pc_o + mips_core_pkg::PC_STEP;
            end
        end
    end

endmodule

// File: src/regfile.sv
// 32 x 32 register file with two read ports, a debug port and write-through
`timescale 1ns/1ps

module regfile (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  mips_isa_pkg::reg_idx_t raddr1_i,
    input  mips_isa_pkg::reg_idx_t raddr2_i,
    input  mips_isa_pkg::reg_idx_t dbg_addr_i,
    input  mips_core_pkg::wb_t     wb_i,
    output mips_isa_pkg::word_t    rdata1_o,
    output mips_isa_pkg::word_t    rdata2_o,
    output mips_isa_pkg::word_t    dbg_data_o
);

    mips_isa_pkg::word_t regs [32];

    // r0 reads zero and a same-cycle write wins over the stored word
    function automatic mips_isa_pkg::word_t read_port(input mips_isa_pkg::reg_idx_t idx,
                                                      input mips_core_pkg::wb_t     wb,
                                                      input mips_isa_pkg::word_t    stored);
        if (idx == '0) begin
            return '0;
        end else if (wb.we && (wb.rd == idx)) begin
            return wb.data;
        end
        return stored;
    endfunction

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_i.we && (wb_i.rd != '0)) begin
            regs[wb_i.rd] <= wb_i.data;
        end
    end

    assign rdata1_o   = read_port(raddr1_i, wb_i, regs[raddr1_i]);
    assign rdata2_o   = read_port(raddr2_i, wb_i, regs[raddr2_i]);
    assign dbg_data_o = read_port(dbg_addr_i, wb_i, regs[dbg_addr_i]);

endmodule
